/* Bender.yml */
package:
  name: edge_data_control

sources:
  - files:
      - logic/edge_data_pkg.sv
      - logic/sync_fifo.sv
      - logic/edge_cmd_select.sv
      - logic/retry_backoff_timer.sv
      - logic/wb_read_fsm.sv
      - logic/edge_data_control.sv
  - target: simulation
    files:
      - sim/edge_data_control_props.sv
      - sim/edge_data_control_tb.sv

/* build.f */
logic/edge_data_pkg.sv
logic/sync_fifo.sv
logic/edge_cmd_select.sv
logic/retry_backoff_timer.sv
logic/wb_read_fsm.sv
logic/edge_data_control.sv
sim/edge_data_control_props.sv
sim/edge_data_control_tb.sv

/* logic/edge_cmd_select.sv */
`timescale 1ns/1ps

module edge_cmd_select import edge_data_pkg::*; #(
	parameter int MAX_RETRIES = 3
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              load,
	input  cmd_src_e          src,
	input  logic [ADDR_W-1:0] data_base,
	input  edge_job_t         job_head,
	input  read_cmd_t         retry_head,
	output logic              job_pop,
	output logic              retry_pop,
	output read_cmd_t         cmd,
	output logic              retry_exhausted
);

	read_cmd_t new_cmd;

	//////////////////////////////
	// Command built from a job
	//////////////////////////////

	always_comb begin
		new_cmd         = '0;
		new_cmd.valid   = job_head.valid;
		new_cmd.dest    = job_head.dest;
		// One 32-bit word per vertex
		new_cmd.address = data_base + {{(ADDR_W - 18){1'b0}}, job_head.dest, 2'b00};
		new_cmd.retries = '0;
		new_cmd.src     = SRC_JOB;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd <= '0;
		end else if (load) begin
			if (src == SRC_RETRY) begin
				cmd         <= retry_head;
				cmd.retries <= retry_head.retries + 1'b1;
				cmd.src     <= SRC_RETRY;
			end else begin
				cmd <= new_cmd;
			end
		end
	end

	// Pop whichever queue the command came from
	assign job_pop   = load && (src == SRC_JOB);
	assign retry_pop = load && (src == SRC_RETRY);

	assign retry_exhausted = (cmd.retries >= 4'(MAX_RETRIES));

endmodule

/* logic/edge_data_control.sv */
`timescale 1ns/1ps

module edge_data_control import edge_data_pkg::*; #(
	parameter int JOB_DEPTH   = 8,
	parameter int DATA_DEPTH  = 8,
	parameter int RETRY_DELAY = 6,
	parameter int MAX_RETRIES = 3
) (
	input  logic       clock,
	input  logic       rstn,
	input  cu_config_t cfg,
	input  edge_job_t  edge_job,
	output logic       edge_request,
	output edge_data_t edge_data,
	input  logic       data_request,
	output wb_req_t    wb_req,
	input  wb_rsp_t    wb_rsp
);

	edge_job_t  job_head;
	read_cmd_t  retry_head;
	read_cmd_t  cmd;
	edge_data_t data_word;
	cmd_src_e   src;
	logic       job_alfull;
	logic       job_avail;
	logic       job_pop;
	logic       retry_avail;
	logic       retry_full;
	logic       retry_pop;
	logic       retry_push;
	logic       data_full;
	logic       data_push;
	logic       load;
	logic       retry_exhausted;
	logic       timer_start;
	logic       timer_ready;

	// Two-entry margin covers a job already on its way
	assign edge_request = !job_alfull;

	//////////////////////////////
	// Queues
	//////////////////////////////

	sync_fifo #(.WIDTH($bits(edge_job_t)), .DEPTH(JOB_DEPTH)) job_fifo_i (
		.clock(clock), .rstn(rstn),
		.push(edge_job.valid), .data_in(edge_job), .pop(job_pop), .data_out(job_head),
		.valid(job_avail), .empty(), .full(), .alfull(job_alfull)
	);

	sync_fifo #(.WIDTH($bits(read_cmd_t)), .DEPTH(JOB_DEPTH)) retry_fifo_i (
		.clock(clock), .rstn(rstn),
		.push(retry_push), .data_in(cmd), .pop(retry_pop), .data_out(retry_head),
		.valid(retry_avail), .empty(), .full(retry_full), .alfull()
	);

	sync_fifo #(.WIDTH($bits(edge_data_t)), .DEPTH(DATA_DEPTH)) data_fifo_i (
		.clock(clock), .rstn(rstn),
		.push(data_push), .data_in(data_word), .pop(data_request), .data_out(edge_data),
		.valid(), .empty(), .full(data_full), .alfull()
	);

	//////////////////////////////
	// Command path and control
	//////////////////////////////

	edge_cmd_select #(.MAX_RETRIES(MAX_RETRIES)) edge_cmd_select_i (
		.clock(clock), .rstn(rstn), .load(load), .src(src), .data_base(cfg.data_base),
		.job_head(job_head), .retry_head(retry_head), .job_pop(job_pop),
		.retry_pop(retry_pop), .cmd(cmd), .retry_exhausted(retry_exhausted)
	);

	retry_backoff_timer #(.RETRY_DELAY(RETRY_DELAY)) retry_backoff_timer_i (
		.clock(clock), .rstn(rstn), .start(timer_start), .ready(timer_ready)
	);

	wb_read_fsm wb_read_fsm_i (
		.clock(clock), .rstn(rstn), .enable(cfg.enable),
		.job_avail(job_avail), .retry_avail(retry_avail), .timer_ready(timer_ready),
		.data_full(data_full), .retry_full(retry_full),
		.cmd(cmd), .retry_exhausted(retry_exhausted), .load(load), .src(src),
		.wb_req(wb_req), .wb_rsp(wb_rsp), .retry_push(retry_push),
		.timer_start(timer_start), .data_push(data_push), .data_word(data_word)
	);

endmodule

/* logic/edge_data_pkg.sv */
package edge_data_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int ADDR_W = 32;

	typedef logic [15:0] vertex_t;

	//////////////////////////////
	// Enums
	//////////////////////////////

	// Where the held command came from
	typedef enum logic {
		SRC_JOB,
		SRC_RETRY
	} cmd_src_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_BUS
	} rd_state_e;

	//////////////////////////////
	// Structs
	//////////////////////////////

	typedef struct packed {
		logic    valid;
		vertex_t dest;
	} edge_job_t;

	typedef struct packed {
		logic        valid;
		vertex_t     dest;
		logic [31:0] data;
		logic        error;
	} edge_data_t;

	typedef struct packed {
		logic              enable;
		logic [ADDR_W-1:0] data_base;
	} cu_config_t;

	// One read in flight or waiting for reissue
	typedef struct packed {
		logic              valid;
		vertex_t           dest;
		logic [ADDR_W-1:0] address;
		logic [3:0]        retries;
		cmd_src_e          src;
	} read_cmd_t;

	// Wishbone classic master outputs
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [3:0]        sel;
	} wb_req_t;

	// Wishbone classic slave outputs
	typedef struct packed {
		logic        ack;
		logic        err;
		logic        rty;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

/* logic/retry_backoff_timer.sv */
`timescale 1ns/1ps

module retry_backoff_timer #(
	parameter int RETRY_DELAY = 6
) (
	input  logic clock,
	input  logic rstn,
	input  logic start,
	output logic ready
);

	localparam int CNT_W = $clog2(RETRY_DELAY + 1);

	logic [CNT_W-1:0] count;

	//////////////////////////////
	// Backoff countdown
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= '0;
		end else if (start) begin
			count <= CNT_W'(RETRY_DELAY);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Retry queue may be served once the count is spent
	assign ready = (count == '0);

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Requests beyond the limits are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Head entry shown ahead and forced to zero while empty
	assign data_out = empty ? '0 : mem[rd_ptr];
	assign empty    = (count == '0);
	assign valid    = !empty;
	assign full     = (count == CNT_W'(DEPTH));
	assign alfull   = (count >= CNT_W'(DEPTH - 2));

endmodule

/* logic/wb_read_fsm.sv */
`timescale 1ns/1ps

module wb_read_fsm import edge_data_pkg::*; (
	input  logic       clock,
	input  logic       rstn,
	input  logic       enable,
	input  logic       job_avail,
	input  logic       retry_avail,
	input  logic       timer_ready,
	input  logic       data_full,
	input  logic       retry_full,
	input  read_cmd_t  cmd,
	input  logic       retry_exhausted,
	output logic       load,
	output cmd_src_e   src,
	output wb_req_t    wb_req,
	input  wb_rsp_t    wb_rsp,
	output logic       retry_push,
	output logic       timer_start,
	output logic       data_push,
	output edge_data_t data_word
);

	rd_state_e state;
	logic      can_start;
	logic      rsp_seen;

	// Room guaranteed for whatever the next response pushes
	assign can_start = enable && !data_full && !retry_full;
	assign rsp_seen  = (state == ST_BUS) && (wb_rsp.ack || wb_rsp.err || wb_rsp.rty);

	//////////////////////////////
	// Source choice
	//////////////////////////////

	always_comb begin
		load = 1'b0;
		src  = SRC_JOB;
		if (state == ST_IDLE && can_start) begin
			// Retries first, but only after their backoff
			if (retry_avail && timer_ready) begin
				load = 1'b1;
				src  = SRC_RETRY;
			end else if (job_avail) begin
				load = 1'b1;
			end
		end
	end

	//////////////////////////////
	// State and bus request
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state  <= ST_IDLE;
			wb_req <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (load)
						state <= ST_LOAD;
				end
				ST_LOAD: begin
					wb_req.cyc <= cmd.valid;
					wb_req.stb <= cmd.valid;
					wb_req.we  <= 1'b0;
					wb_req.adr <= cmd.address;
					wb_req.sel <= 4'hf;
					state      <= cmd.valid ? ST_BUS : ST_IDLE;
				end
				ST_BUS: begin
					// Exactly one response ends the cycle
					if (rsp_seen) begin
						wb_req.cyc <= 1'b0;
						wb_req.stb <= 1'b0;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Result routing
	//////////////////////////////

	assign retry_push  = rsp_seen && wb_rsp.rty && !retry_exhausted;
	assign timer_start = retry_push;
	assign data_push   = rsp_seen && (wb_rsp.ack || wb_rsp.err || retry_exhausted);

	always_comb begin
		data_word       = '0;
		data_word.valid = cmd.valid;
		data_word.dest  = cmd.dest;
		data_word.data  = wb_rsp.ack ? wb_rsp.dat : 32'h0;
		data_word.error = !wb_rsp.ack;
	end

endmodule

/* sim/edge_data_control_props.sv */
`timescale 1ns/1ps

module edge_data_control_props import edge_data_pkg::*; (
	input logic    clock,
	input logic    rstn,
	input wb_req_t wb_req,
	input wb_rsp_t wb_rsp,
	input logic    data_push
);

	logic rsp_any;
	int   fail_count = 0;

	assign rsp_any = wb_rsp.ack || wb_rsp.err || wb_rsp.rty;

	//////////////////////////////
	// Wishbone classic handshake
	//////////////////////////////

	adr_held: assert property (@(posedge clock) disable iff (!rstn)
		wb_req.stb && !rsp_any |=> $stable(wb_req.adr))
	else begin
		fail_count++;
		$error("wb_req.adr moved before the slave answered");
	end

	// One answer ends the cycle
	cycle_ends: assert property (@(posedge clock) disable iff (!rstn)
		wb_req.stb && rsp_any |=> !wb_req.cyc && !wb_req.stb)
	else begin
		fail_count++;
		$error("cyc or stb still high after the slave answered");
	end

	push_on_answer: assert property (@(posedge clock) disable iff (!rstn)
		data_push |-> wb_req.stb && rsp_any)
	else begin
		fail_count++;
		$error("Result pushed without a bus answer");
	end

endmodule

/* sim/edge_data_control_tb.sv */
`timescale 1ns/1ps

module edge_data_control_tb import edge_data_pkg::*; ();

	localparam int NUM_ROWS    = 10;
	localparam int RETRY_DELAY = 6;
	localparam int MAX_RETRIES = 3;
	localparam int CYCLE_LIMIT = NUM_ROWS * 5 * (RETRY_DELAY + 10) + 400;
	localparam logic [31:0] DATA_BASE = 32'h4000_0000;

	// Each row holds dest, memory word, rty answers before the last one and whether it is err
	typedef struct packed {
		vertex_t     dest;
		logic [31:0] word;
		logic [3:0]  rty;
		logic        err;
	} row_t;

	logic       clock;
	logic       rstn;
	cu_config_t cfg;
	edge_job_t  edge_job;
	logic       edge_request;
	edge_data_t edge_data;
	logic       data_request;
	wb_req_t    wb_req;
	wb_rsp_t    wb_rsp;

	row_t stim [NUM_ROWS];
	int   delivered [NUM_ROWS];
	int   rty_given [NUM_ROWS];
	int   rty_cycle [NUM_ROWS];
	int   cycle;
	int   popped;
	int   value_errors;
	int   other_errors;
	logic holding;
	logic request_dropped;

	edge_data_control #(.RETRY_DELAY(RETRY_DELAY), .MAX_RETRIES(MAX_RETRIES)) edge_data_control_i (
		.clock(clock), .rstn(rstn), .cfg(cfg), .edge_job(edge_job), .edge_request(edge_request),
		.edge_data(edge_data), .data_request(data_request), .wb_req(wb_req), .wb_rsp(wb_rsp)
	);

	bind wb_read_fsm edge_data_control_props props_i (
		.clock(clock), .rstn(rstn), .wb_req(wb_req), .wb_rsp(wb_rsp), .data_push(data_push)
	);

	function automatic int row_of_dest(input vertex_t dest);
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (stim[i].dest == dest)
				return i;
		end
		return -1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			value_errors++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = !clock;
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	//////////////////////////////
	// Consumer
	//////////////////////////////

	initial begin : consumer
		data_request = 1'b0;
		holding      = 1'b0;
		wait (rstn === 1'b1);
		// Nothing popped at first, so the queues back up
		holding <= 1'b1;
		repeat (30) @(posedge clock);
		holding <= 1'b0;
		forever begin
			@(posedge clock);
			data_request <= ($urandom_range(3, 0) != 0);
		end
	end

	//////////////////////////////
	// Wishbone slave model
	//////////////////////////////

	initial begin : slave
		int   idx;
		int   waits;
		logic busy;
		wb_rsp = '0;
		busy   = 1'b0;
		idx    = -1;
		waits  = 0;
		forever begin
			@(posedge clock);
			if (wb_rsp.ack || wb_rsp.err || wb_rsp.rty) begin
				// Answer lasts one cycle
				wb_rsp <= '0;
			end else if (wb_req.stb) begin
				if (!busy) begin
					busy  = 1'b1;
					waits = $urandom_range(3, 0);
					idx   = row_of_dest(vertex_t'((wb_req.adr - DATA_BASE) >> 2));
					assert (idx >= 0) else begin
						other_errors++;
						$display("Read of address %h belongs to no job", wb_req.adr);
					end
					if (idx >= 0) begin
						check_value("wb_req.adr", wb_req.adr, DATA_BASE + {stim[idx].dest, 2'b00});
						if (rty_given[idx] > 0) begin
							assert (cycle - rty_cycle[idx] >= RETRY_DELAY) else begin
								other_errors++;
								$display("dest %0d reissued only %0d cycles after its retry",
									stim[idx].dest, cycle - rty_cycle[idx]);
							end
						end
					end
				end
				if (waits > 0) begin
					waits--;
				end else begin
					busy = 1'b0;
					// Fields are ack, err, rty, dat
					if (idx < 0) begin
						wb_rsp <= {3'b010, 32'h0};
					end else if (rty_given[idx] < stim[idx].rty) begin
						rty_given[idx]++;
						rty_cycle[idx] = cycle;
						wb_rsp <= {3'b001, 32'h0};
					end else if (stim[idx].err) begin
						wb_rsp <= {3'b010, 32'h0};
					end else begin
						wb_rsp <= {3'b100, stim[idx].word};
					end
				end
			end
		end
	end

	//////////////////////////////
	// Bus monitor and scoreboard
	//////////////////////////////

	always @(posedge clock) begin : monitor
		int   idx;
		logic exp_error;
		if (rstn) begin
			if (wb_req.cyc || wb_req.stb) begin
				check_value("wb_req.cyc", wb_req.cyc, wb_req.stb);
				check_value("wb_req.we", wb_req.we, 1'b0);
				check_value("wb_req.sel", wb_req.sel, 4'hf);
			end
			if (holding && !edge_request)
				request_dropped <= 1'b1;
			if (edge_data.valid && data_request) begin
				idx = row_of_dest(edge_data.dest);
				assert (idx >= 0) else begin
					other_errors++;
					$display("Result for dest %0d, which was never sent as a job", edge_data.dest);
				end
				if (idx >= 0) begin
					assert (delivered[idx] == 0) else begin
						other_errors++;
						$display("dest %0d delivered more than once", edge_data.dest);
					end
					delivered[idx]++;
					// Too many retries or an err answer ends in an error result
					exp_error = (stim[idx].rty > MAX_RETRIES) || stim[idx].err;
					check_value("edge_data.error", edge_data.error, exp_error);
					check_value("edge_data.data", edge_data.data, exp_error ? 32'h0 : stim[idx].word);
				end
				popped <= popped + 1;
			end
		end
	end

	initial begin : main
		int next_row;
		void'($urandom(39));
		rstn            = 1'b0;
		cfg             = {1'b1, DATA_BASE};
		edge_job        = '0;
		cycle           = 0;
		popped          = 0;
		value_errors    = 0;
		other_errors    = 0;
		request_dropped = 1'b0;
		stim[0] = {16'd3, 32'h0a11_0003, 4'd0, 1'b0};
		stim[1] = {16'd17, 32'h0a11_0011, 4'd1, 1'b0};
		stim[2] = {16'd40, 32'h5eed_0028, 4'd2, 1'b0};
		stim[3] = {16'd41, 32'h5eed_0029, 4'd3, 1'b0};
		stim[4] = {16'd100, 32'hbad0_0064, 4'd4, 1'b0};
		stim[5] = {16'd7, 32'h0e77_0007, 4'd0, 1'b1};
		stim[6] = {16'd250, 32'h0e77_00fa, 4'd2, 1'b1};
		stim[7] = {16'd1023, 32'hc0de_03ff, 4'd0, 1'b0};
		stim[8] = {16'd512, 32'hbad0_0200, 4'd5, 1'b0};
		stim[9] = {16'd65535, 32'hffff_0001, 4'd1, 1'b0};
		for (int i = 0; i < NUM_ROWS; i++) begin
			delivered[i] = 0;
			rty_given[i] = 0;
			rty_cycle[i] = 0;
		end
		repeat (8) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		check_value("wb_req.cyc", wb_req.cyc, 1'b0);
		check_value("wb_req.stb", wb_req.stb, 1'b0);
		check_value("edge_data.valid", edge_data.valid, 1'b0);
		check_value("edge_request", edge_request, 1'b1);

		// One job per cycle while the unit asks for more
		next_row = 0;
		while (next_row < NUM_ROWS && cycle < CYCLE_LIMIT) begin
			@(posedge clock);
			if (edge_request) begin
				edge_job <= {1'b1, stim[next_row].dest};
				next_row++;
			end else begin
				edge_job <= '0;
			end
		end
		@(posedge clock);
		edge_job <= '0;

		while (popped < NUM_ROWS && cycle < CYCLE_LIMIT)
			@(posedge clock);
		assert (cycle < CYCLE_LIMIT) else begin
			other_errors++;
			$display("Timeout at cycle %0d with %0d of %0d results", cycle, popped, NUM_ROWS);
		end
		// Late duplicates still show up here
		repeat (20) @(posedge clock);
		for (int i = 0; i < NUM_ROWS; i++) begin
			assert (delivered[i] != 0) else begin
				other_errors++;
				$display("dest %0d was never delivered", stim[i].dest);
			end
		end
		assert (request_dropped) else begin
			other_errors++;
			$display("edge_request stayed high through the consumer hold-off");
		end

		$display("Errors: %0d wrong values, %0d other failures, %0d property failures",
			value_errors, other_errors, edge_data_control_i.wb_read_fsm_i.props_i.fail_count);
		if (value_errors + other_errors + edge_data_control_i.wb_read_fsm_i.props_i.fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
